//--- src/wb_pkg.sv
// ######################################################################
// Wishbone bus definitions.
// Widths and the request and response structs of the classic
// single-transfer bus between the master and the memory subsystem.
// ######################################################################

package wb_pkg;

	// ##################################################################
	// Bus widths
	// ##################################################################

	localparam int ADDR_W = 32;         // Byte address width.
	localparam int DATA_W = 32;         // Data word width.
	localparam int SEL_W  = DATA_W / 8; // One select bit per byte lane.

	// ##################################################################
	// Request and response
	// ##################################################################

	// Master to slave. Held steady from stb until ack or err.
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [ADDR_W-1:0] adr;
		logic [SEL_W-1:0]  sel;
		logic [DATA_W-1:0] dat;
	} wb_req_t;

	// Slave to master. At most one of ack and err per transfer.
	typedef struct packed {
		logic              ack;
		logic              err;
		logic [DATA_W-1:0] dat;
	} wb_rsp_t;

endpackage

//--- src/mem_map_pkg.sv
// ######################################################################
// Memory map definitions.
// Base address of the banked memory region and the sizing of the
// bank-index field that the decoder and the response mux share.
// ######################################################################

package mem_map_pkg;

	// ##################################################################
	// Address map
	// ##################################################################

	// Byte address of word 0 in bank 0. Everything below the base,
	// once subtracted, is treated as a plain offset into the region.
	localparam logic [31:0] MAP_BASE = 32'h0000_0000;

	// ##################################################################
	// Bank indexing
	// ##################################################################

	// Largest bank count the index field can name.
	localparam int MAX_BANKS = 16;

	// Width of the bank index carried from the decoder to the mux.
	localparam int BANK_IDX_W = $clog2(MAX_BANKS);

	// A bank count above MAX_BANKS would need a wider index field,
	// so the top level keeps NUM_BANKS at or below this bound.

endpackage

//--- src/wb_addr_decoder.sv
// ######################################################################
// Wishbone address decoder.
// Splits the master address into bank index and word offset, strobes
// only the addressed bank, and answers unmapped addresses with a
// registered one-cycle error.
// ######################################################################

`timescale 1ns/1ns

module wb_addr_decoder #(
	parameter int NUM_BANKS      = 4,
	parameter int BANK_ADDR_BITS = 8
) (
	input  logic                                clk,
	input  logic                                i_reset,
	input  wb_pkg::wb_req_t                     i_wb_req,
	output wb_pkg::wb_req_t                     o_bank_req [NUM_BANKS],
	output logic [mem_map_pkg::BANK_IDX_W-1:0]  o_bank_sel,
	output logic                                o_err_rsp
);

	// Width of everything above the word offset and the byte lanes.
	localparam int IDX_FULL_W = wb_pkg::ADDR_W - BANK_ADDR_BITS - 2;

	logic [wb_pkg::ADDR_W-1:0] rel_adr;   // Address relative to the map base.
	logic [IDX_FULL_W-1:0]     idx_full;  // Bank index plus any higher bits.
	logic                      mapped;
	logic                      strobe;

	// ##################################################################
	// Address split
	// ##################################################################

	assign rel_adr  = i_wb_req.adr - mem_map_pkg::MAP_BASE;
	assign idx_full = rel_adr[wb_pkg::ADDR_W-1:BANK_ADDR_BITS+2];

	// A nonzero bit above the index makes the full value exceed
	// NUM_BANKS, so one compare covers both unmapped cases.
	assign mapped = (idx_full < IDX_FULL_W'(NUM_BANKS));
	assign strobe = i_wb_req.cyc & i_wb_req.stb;

	// ##################################################################
	// Request fan-out
	// ##################################################################

	always_comb begin
		for (int i = 0; i < NUM_BANKS; i++) begin
			o_bank_req[i]     = i_wb_req;
			o_bank_req[i].adr = rel_adr; // Banks take the offset field from here.
			o_bank_req[i].stb = i_wb_req.stb & mapped & (idx_full == IDX_FULL_W'(i));
		end
	end

	// ##################################################################
	// Transfer tracking and error response
	// ##################################################################

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_bank_sel <= '0;
			o_err_rsp  <= 1'b0;
		end else begin
			if (strobe) begin
				o_bank_sel <= idx_full[mem_map_pkg::BANK_IDX_W-1:0]; // Steers read data back.
			end
			// One-cycle pulse, the held strobe does not retrigger it.
			o_err_rsp <= strobe & ~mapped & ~o_err_rsp;
		end
	end

endmodule

//--- src/wb_sram_bank.sv
// ######################################################################
// Wishbone SRAM bank.
// Word-wide memory of 2^BANK_ADDR_BITS words with byte selects. Each
// strobed transfer gets a registered ack one cycle later, together
// with the registered read word.
// ######################################################################

`timescale 1ns/1ns

module wb_sram_bank #(
	parameter int BANK_ADDR_BITS = 8
) (
	input  logic            clk,
	input  logic            i_reset,
	input  wb_pkg::wb_req_t i_req,
	output wb_pkg::wb_rsp_t o_rsp
);

	localparam int DEPTH = 2 ** BANK_ADDR_BITS;

	logic [wb_pkg::DATA_W-1:0] mem [DEPTH];

	logic [BANK_ADDR_BITS-1:0] offset;
	logic                      accept;
	logic                      ack_q;
	logic [wb_pkg::DATA_W-1:0] rd_dat_q;

	// Word offset sits just above the two byte-lane bits.
	assign offset = i_req.adr[BANK_ADDR_BITS+1:2];

	// A strobe still high while ack is out belongs to the transfer
	// being answered, so it is not taken a second time.
	assign accept = i_req.cyc & i_req.stb & ~ack_q;

	// ##################################################################
	// Storage
	// ##################################################################

	always_ff @(posedge clk) begin
		if (accept && i_req.we) begin
			for (int b = 0; b < wb_pkg::SEL_W; b++) begin
				if (i_req.sel[b]) begin
					mem[offset][b*8 +: 8] <= i_req.dat[b*8 +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rd_dat_q <= mem[offset]; // Captured on writes too, the master ignores it.
		end
	end

	// ##################################################################
	// Acknowledge
	// ##################################################################

	always_ff @(posedge clk) begin
		if (i_reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= accept; // High for one cycle per accepted strobe.
		end
	end

	always_comb begin
		o_rsp.ack = ack_q;
		o_rsp.err = 1'b0; // Every offset in a bank is valid.
		o_rsp.dat = rd_dat_q;
	end

endmodule

//--- src/wb_resp_mux.sv
// ######################################################################
// Wishbone response multiplexer.
// Merges the bank acknowledges and the decoder error onto the single
// master response, and picks the read data of the bank in use.
// ######################################################################

`timescale 1ns/1ns

module wb_resp_mux #(
	parameter int NUM_BANKS = 4
) (
	input  wb_pkg::wb_rsp_t                    i_bank_rsp [NUM_BANKS],
	input  logic [mem_map_pkg::BANK_IDX_W-1:0] i_bank_sel,
	input  logic                               i_err_rsp,
	output wb_pkg::wb_rsp_t                    o_wb_rsp
);

	logic                      any_ack;
	logic [wb_pkg::DATA_W-1:0] sel_dat;

	// ##################################################################
	// Acknowledge merge
	// ##################################################################

	// Only the addressed bank was strobed, so at most one ack is high.
	always_comb begin
		any_ack = 1'b0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			any_ack = any_ack | i_bank_rsp[i].ack;
		end
	end

	// ##################################################################
	// Data select
	// ##################################################################

	always_comb begin
		sel_dat = '0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			if (i_bank_sel == mem_map_pkg::BANK_IDX_W'(i)) begin
				sel_dat = i_bank_rsp[i].dat;
			end
		end
	end

	// Data is held at zero outside an ack, which also keeps it zero
	// after reset while the bank registers are still unknown.
	always_comb begin
		o_wb_rsp.ack = any_ack;
		o_wb_rsp.err = i_err_rsp;
		o_wb_rsp.dat = any_ack ? sel_dat : '0;
	end

endmodule

//--- src/wb_mem_subsystem.sv
// ######################################################################
// Banked Wishbone memory subsystem.
// One classic slave port feeding an address decoder, a row of
// identical SRAM banks and a response mux back to the master.
// ######################################################################

`timescale 1ns/1ns

module wb_mem_subsystem #(
	parameter int NUM_BANKS      = 4,
	parameter int BANK_ADDR_BITS = 8
) (
	input  logic            clk,
	input  logic            i_reset,
	input  wb_pkg::wb_req_t i_wb_req,
	output wb_pkg::wb_rsp_t o_wb_rsp
);

	wb_pkg::wb_req_t                    bank_req [NUM_BANKS];
	wb_pkg::wb_rsp_t                    bank_rsp [NUM_BANKS];
	logic [mem_map_pkg::BANK_IDX_W-1:0] bank_sel;
	logic                               err_rsp;

	// ##################################################################
	// Decode
	// ##################################################################

	wb_addr_decoder #(
		.NUM_BANKS      (NUM_BANKS),
		.BANK_ADDR_BITS (BANK_ADDR_BITS)
	) u_decoder (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_wb_req   (i_wb_req),
		.o_bank_req (bank_req),
		.o_bank_sel (bank_sel),
		.o_err_rsp  (err_rsp)
	);

	// ##################################################################
	// Banks
	// ##################################################################

	for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
		wb_sram_bank #(
			.BANK_ADDR_BITS (BANK_ADDR_BITS)
		) u_bank (
			.clk     (clk),
			.i_reset (i_reset),
			.i_req   (bank_req[g]),
			.o_rsp   (bank_rsp[g])
		);
	end

	// ##################################################################
	// Response
	// ##################################################################

	wb_resp_mux #(
		.NUM_BANKS (NUM_BANKS)
	) u_resp_mux (
		.i_bank_rsp (bank_rsp),
		.i_bank_sel (bank_sel),
		.i_err_rsp  (err_rsp),
		.o_wb_rsp   (o_wb_rsp)
	);

endmodule

//--- dv/wb_mem_subsystem_checker.sv
// ######################################################################
// Protocol checker for the Wishbone memory subsystem.
// Concurrent assertions on the master port, bound to the top level.
// ######################################################################

`timescale 1ns/1ns

module wb_mem_subsystem_checker (
	input logic            clk,
	input logic            i_reset,
	input wb_pkg::wb_req_t i_wb_req,
	input wb_pkg::wb_rsp_t i_wb_rsp
);

	logic strobe;                // Master asks for a transfer.
	logic responding;            // Slave answers with ack or err.
	int   assert_fail_count = 0; // Number of failed assertions so far.

	assign strobe     = i_wb_req.cyc & i_wb_req.stb;
	assign responding = i_wb_rsp.ack | i_wb_rsp.err;

	// The port stays silent and its data stays zero for the cycle after every reset cycle.
	a_quiet_after_reset: assert property (@(posedge clk)
		i_reset |=> (!responding && i_wb_rsp.dat == '0))
	else begin
		assert_fail_count++;
		$error("ack, err or data was nonzero in the cycle after a reset cycle");
	end

	// A fresh strobe gets exactly one kind of answer one cycle later.
	a_answer_next_cycle: assert property (@(posedge clk) disable iff (i_reset)
		(strobe && !responding) |=> (i_wb_rsp.ack ^ i_wb_rsp.err))
	else begin
		assert_fail_count++;
		$error("strobe was not answered by exactly one of ack and err");
	end

	a_ack_err_exclusive: assert property (@(posedge clk) disable iff (i_reset)
		!(i_wb_rsp.ack && i_wb_rsp.err))
	else begin
		assert_fail_count++;
		$error("ack and err were high together");
	end

	// No answer appears unless the master strobed in the cycle before.
	a_no_unsolicited: assert property (@(posedge clk) disable iff (i_reset)
		!strobe |=> !responding)
	else begin
		assert_fail_count++;
		$error("ack or err rose without cyc and stb");
	end

	a_single_cycle: assert property (@(posedge clk) disable iff (i_reset)
		responding |=> !responding)
	else begin
		assert_fail_count++;
		$error("ack or err stayed high for two cycles");
	end

endmodule

bind wb_mem_subsystem wb_mem_subsystem_checker u_checker (
	.clk      (clk),
	.i_reset  (i_reset),
	.i_wb_req (i_wb_req),
	.i_wb_rsp (o_wb_rsp)
);

//--- dv/wb_mem_subsystem_tb.sv
// ######################################################################
// Testbench for the banked Wishbone memory subsystem.
// Plays the bus master with directed and LCG-random transfers and
// checks every response against a reference memory model.
// ######################################################################

`timescale 1ns/1ns

module wb_mem_subsystem_tb;

	localparam int NUM_BANKS      = 4;
	localparam int BANK_ADDR_BITS = 8;
	localparam int BANK_WORDS     = 2 ** BANK_ADDR_BITS;
	localparam int CLK_HALF       = 10;
	localparam int RESP_TIMEOUT   = 16; // Cycles allowed for ack or err.
	localparam int RANDOM_OPS     = 200;

	localparam logic [31:0] BANK_MASK = 32'(BANK_WORDS * 4 - 1);
	localparam logic [31:0] MAP_BYTES = 32'(NUM_BANKS * BANK_WORDS * 4);

	logic            clk;
	logic            i_reset;
	wb_pkg::wb_req_t wb_req;
	wb_pkg::wb_rsp_t wb_rsp;

	logic [31:0] ref_mem [int]; // Expected words, keyed by bank and offset.
	logic [31:0] rng_state;

	wb_mem_subsystem uut (
		.clk      (clk),
		.i_reset  (i_reset),
		.i_wb_req (wb_req),
		.o_wb_rsp (wb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// ##################################################################
	// Helpers
	// ##################################################################

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at the first error.");
	endtask

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic [31:0] bank_addr(input int bank, input int offset);
		return mem_map_pkg::MAP_BASE + 32'(bank * BANK_WORDS + offset) * 32'd4;
	endfunction

	// Mapped when everything above the word offset names an existing bank.
	function automatic logic addr_is_mapped(input logic [31:0] adr);
		logic [31:0] rel;
		rel = adr - mem_map_pkg::MAP_BASE;
		return (rel >> (BANK_ADDR_BITS + 2)) < 32'(NUM_BANKS);
	endfunction

	function automatic int model_key(input logic [31:0] adr);
		logic [31:0] rel;
		rel = adr - mem_map_pkg::MAP_BASE;
		return int'(rel >> 2); // Bank index and offset side by side.
	endfunction

	// An odd multiplier keeps every word of the map distinct.
	function automatic logic [31:0] fill_word(input int key);
		return 32'(key) * 32'h9e37_79b1 + 32'h0101_0101;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] sel);
		logic [31:0] merged;
		merged = old_word;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				merged[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return merged;
	endfunction

	// ##################################################################
	// Bus tasks
	// ##################################################################

	// Strobes on a falling edge and ends the cycle once ack or err shows.
	task automatic run_transfer(input logic we, input logic [31:0] adr,
		input logic [3:0] sel, input logic [31:0] wdat, output logic [31:0] rdat);
		int   cycles;
		logic exp_ack;
		@(negedge clk);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: wdat};
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > RESP_TIMEOUT) begin
				report_failure($sformatf("No ack or err within %0d cycles for address %08h.",
					RESP_TIMEOUT, adr));
			end
		end while (!(wb_rsp.ack || wb_rsp.err));
		exp_ack = addr_is_mapped(adr);
		assert (wb_rsp.ack == exp_ack && wb_rsp.err == !exp_ack) else begin
			report_failure($sformatf("[FAIL] o_wb_rsp ack/err: expected %0h/%0h, got %0h/%0h at %08h",
				exp_ack, !exp_ack, wb_rsp.ack, wb_rsp.err, adr));
		end
		rdat   = wb_rsp.dat;
		wb_req = '0;
	endtask

	task automatic write_word(input logic [31:0] adr, input logic [3:0] sel,
		input logic [31:0] dat);
		logic [31:0] ignored;
		int          key;
		run_transfer(1'b1, adr, sel, dat, ignored);
		key = model_key(adr);
		if (addr_is_mapped(adr)) begin
			if (ref_mem.exists(key)) begin
				ref_mem[key] = merge_bytes(ref_mem[key], dat, sel);
			end else begin
				ref_mem[key] = dat; // The fill pass writes whole words.
			end
		end
	endtask

	task automatic read_word(input logic [31:0] adr);
		logic [31:0] rdat;
		logic [31:0] expected;
		run_transfer(1'b0, adr, 4'hf, 32'h0, rdat);
		if (addr_is_mapped(adr) && ref_mem.exists(model_key(adr))) begin
			expected = ref_mem[model_key(adr)];
			assert (rdat === expected) else begin
				report_failure($sformatf("[FAIL] o_wb_rsp.dat: expected %08h, got %08h at %08h",
					expected, rdat, adr));
			end
		end
	endtask

	// The bound checker counts its failed assertions.
	always @(negedge clk) begin
		if (uut.u_checker.assert_fail_count != 0) begin
			report_failure("A protocol assertion in the bound checker failed.");
		end
	end

	// ##################################################################
	// Stimulus
	// ##################################################################

	initial begin
		logic [31:0] r;
		logic [31:0] rel;
		logic [31:0] hi;
		wb_req    = '0;
		i_reset   = 1'b1;
		rng_state = 32'hb325;
		repeat (4) @(posedge clk);
		@(negedge clk);
		i_reset = 1'b0;
		repeat (2) @(negedge clk);

		// Round trip through every word of every bank.
		for (int k = 0; k < NUM_BANKS * BANK_WORDS; k++) begin
			write_word(bank_addr(k / BANK_WORDS, k % BANK_WORDS), 4'hf, fill_word(k));
		end
		for (int k = 0; k < NUM_BANKS * BANK_WORDS; k++) begin
			read_word(bank_addr(k / BANK_WORDS, k % BANK_WORDS));
		end

		// Same offset in each bank holds its own value.
		for (int b = 0; b < NUM_BANKS; b++) begin
			write_word(bank_addr(b, 8'h3c), 4'hf, 32'hc0de_0000 | 32'(b));
		end
		for (int b = 0; b < NUM_BANKS; b++) begin
			read_word(bank_addr(b, 8'h3c));
		end

		// All sixteen byte-select patterns.
		for (int s = 0; s < 16; s++) begin
			write_word(bank_addr(s % NUM_BANKS, 16 + s), 4'(s), 32'hdead_beef ^ 32'(s));
			read_word(bank_addr(s % NUM_BANKS, 16 + s));
		end

		// Index past the last bank, then a bit set far above the index.
		write_word(bank_addr(NUM_BANKS, 5), 4'hf, 32'hbad0_0001);
		write_word(32'h8000_0000 | bank_addr(1, 6), 4'hf, 32'hbad0_0002);
		read_word(bank_addr(NUM_BANKS + 3, 7));
		read_word(bank_addr(0, 5));
		read_word(bank_addr(1, 6));
		read_word(bank_addr(3, 7));

		for (int n = 0; n < RANDOM_OPS; n++) begin
			r   = lcg_next();
			rel = 32'(int'(r[17:16]) * BANK_WORDS + int'(r[15:8])) * 32'd4;
			rel = rel | 32'(r[19:18]); // Byte-lane bits are ignored.
			if (r[7:5] == 3'd0) begin
				hi = lcg_next() & ~BANK_MASK;
				if (hi < MAP_BYTES) begin
					hi = hi | MAP_BYTES;
				end
				rel = (rel & BANK_MASK) | hi;
			end
			if (r[0]) begin
				write_word(mem_map_pkg::MAP_BASE + rel, r[4:1], lcg_next());
			end else begin
				read_word(mem_map_pkg::MAP_BASE + rel);
			end
		end

		repeat (2) @(negedge clk);
		if (uut.u_checker.assert_fail_count == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			report_failure("A protocol assertion in the bound checker failed.");
		end
	end

endmodule

//--- files.f
src/wb_pkg.sv
src/mem_map_pkg.sv
src/wb_addr_decoder.sv
src/wb_sram_bank.sv
src/wb_resp_mux.sv
src/wb_mem_subsystem.sv
dv/wb_mem_subsystem_checker.sv
dv/wb_mem_subsystem_tb.sv

//--- Makefile
# Verilator build and run for the banked Wishbone memory subsystem.
# Any variable below can be overridden on the command line,
# for example: make LOG=run1.log

VERILATOR ?= verilator
TOP       ?= wb_mem_subsystem_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation finished: PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# The simulator status is ignored here, the log decides the result.
run: build
	-$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result taken from $(LOG): pass message found."; \
	else \
		echo "Result taken from $(LOG): pass message missing."; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
